//--- logic/lsq_macros.svh
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// ==============================
// Queue depths
// ==============================
// Both depths must be powers of two
`define LSQ_SQ_DEPTH 8
`define LSQ_LQ_DEPTH 8

// ==============================
// Datapath widths
// ==============================
`define LSQ_ADDR_WIDTH 32
`define LSQ_DATA_WIDTH 32
`define LSQ_ROB_WIDTH 5

`endif

//--- logic/lsq_pkg.sv
`default_nettype none
`include "lsq_macros.svh"

package lsq_pkg;

    // Word address, data word, ROB slot
    typedef logic [`LSQ_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`LSQ_DATA_WIDTH-1:0] data_t;
    typedef logic [`LSQ_ROB_WIDTH-1:0] rob_idx_t;

    // Ring pointers, index plus wrap bit
    typedef logic [$clog2(`LSQ_SQ_DEPTH):0] sq_ptr_t;
    typedef logic [$clog2(`LSQ_LQ_DEPTH):0] lq_ptr_t;

    // ==============================
    // Port bundles
    // ==============================
    typedef struct packed {
        logic     valid;
        logic     is_store;
        rob_idx_t rob_idx;
    } dispatch_t;

    // Address and store data from the execution unit
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        addr_t    addr;
        data_t    data;
    } exec_result_t;

    // Same layout on load and store ports
    typedef struct packed {
        logic     valid;
        addr_t    addr;
        data_t    data;
        rob_idx_t rob_idx;
    } mem_req_t;

    typedef struct packed {
        logic     valid;
        data_t    data;
        rob_idx_t rob_idx;
    } mem_resp_t;

    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
        data_t    data;
    } writeback_t;

    // Store drain FSM
    typedef enum logic {
        DRAIN_IDLE,
        DRAIN_REQUEST
    } drain_state_t;

endpackage

`default_nettype wire

//--- logic/queue_pointers.sv
`timescale 1ns/1ps
`default_nettype none

module queue_pointers #(
    parameter int DEPTH = 8
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       push_i,
    input  logic                       pop_i,
    output logic [$clog2(DEPTH):0]     head_o,
    output logic [$clog2(DEPTH):0]     tail_o,
    output logic [$clog2(DEPTH+1)-1:0] count_o,
    output logic                       full_o
);

    // Index bits plus one wrap bit, DEPTH a power of two
    localparam int PTR_W = $clog2(DEPTH) + 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    // ==============================
    // Pointer and count update
    // ==============================
    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                tail_q <= tail_q + PTR_W'(1);
            end
            if (pop_i) begin
                head_q <= head_q + PTR_W'(1);
            end
            // Push and pop together leave the count alone
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    assign head_o  = head_q;
    assign tail_o  = tail_q;
    assign count_o = count_q;
    // Full at DEPTH entries
    assign full_o  = (count_q == CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- logic/store_drain_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module store_drain_fsm
    import lsq_pkg::*;
(
    input  logic clock,
    input  logic reset,
    input  logic head_ready_i,
    input  logic accept_i,
    output logic request_o,
    output logic pop_o
);

    drain_state_t state_q;
    drain_state_t state_d;

    // ==============================
    // Next state
    // ==============================
    always_comb begin
        state_d = state_q;
        case (state_q)
            DRAIN_IDLE: begin
                // Head has address, data and commit
                if (head_ready_i) begin
                    state_d = DRAIN_REQUEST;
                end
            end
            DRAIN_REQUEST: begin
                // Hold the request under back-pressure
                if (accept_i) begin
                    state_d = DRAIN_IDLE;
                end
            end
            default: begin
                state_d = DRAIN_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= DRAIN_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request straight from the state register
    assign request_o = (state_q == DRAIN_REQUEST);
    // Entry leaves in the accept cycle
    assign pop_o     = request_o && accept_i;

endmodule

`default_nettype wire

//--- logic/store_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsq_macros.svh"

module store_queue
    import lsq_pkg::*;
(
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                enq_i,
    input  rob_idx_t                            enq_rob_idx_i,
    input  exec_result_t                        exec_i,
    input  logic                                commit_valid_i,
    input  rob_idx_t                            commit_rob_idx_i,
    output mem_req_t                            store_req_o,
    input  logic                                store_accept_i,
    output logic                                full_o,
    output sq_ptr_t                             head_o,
    output sq_ptr_t                             tail_o,
    output logic [$clog2(`LSQ_SQ_DEPTH+1)-1:0] count_o
);

    localparam int DEPTH = `LSQ_SQ_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    // Entry payload
    rob_idx_t entry_rob [DEPTH];
    addr_t    entry_addr [DEPTH];
    data_t    entry_data [DEPTH];

    // Entry status
    logic [DEPTH-1:0] entry_valid;
    logic [DEPTH-1:0] addr_known;
    logic [DEPTH-1:0] committed;

    logic [DEPTH-1:0] exec_hit;
    logic [DEPTH-1:0] commit_hit;
    logic             enq_ok;
    logic             pop;
    logic             head_ready;
    logic             drain_req;
    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] tail_idx;

    // Dispatch into a full queue is dropped
    assign enq_ok   = enq_i && !full_o;
    assign head_idx = head_o[IDX_W-1:0];
    assign tail_idx = tail_o[IDX_W-1:0];

    queue_pointers #(
        .DEPTH(DEPTH)
    ) i_pointers (
        .clock  (clock),
        .reset  (reset),
        .push_i (enq_ok),
        .pop_i  (pop),
        .head_o (head_o),
        .tail_o (tail_o),
        .count_o(count_o),
        .full_o (full_o)
    );

    // ==============================
    // ROB index match
    // ==============================
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            exec_hit[i]   = entry_valid[i] && exec_i.valid
                            && (entry_rob[i] == exec_i.rob_idx);
            commit_hit[i] = entry_valid[i] && commit_valid_i
                            && (entry_rob[i] == commit_rob_idx_i);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            addr_known  <= '0;
            committed   <= '0;
        end else begin
            addr_known <= addr_known | exec_hit;
            committed  <= committed | commit_hit;
            if (pop) begin
                entry_valid[head_idx] <= 1'b0;
            end
            // New entry starts with nothing known
            if (enq_ok) begin
                entry_valid[tail_idx] <= 1'b1;
                addr_known[tail_idx]  <= 1'b0;
                committed[tail_idx]   <= 1'b0;
            end
        end
    end

    // Payload writes
    always_ff @(posedge clock) begin
        if (enq_ok) begin
            entry_rob[tail_idx] <= enq_rob_idx_i;
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (exec_hit[i]) begin
                entry_addr[i] <= exec_i.addr;
                entry_data[i] <= exec_i.data;
            end
        end
    end

    // ==============================
    // Drain
    // ==============================
    // Exec result carries address and data together
    assign head_ready = entry_valid[head_idx] && addr_known[head_idx] && committed[head_idx];

    store_drain_fsm i_drain_fsm (
        .clock       (clock),
        .reset       (reset),
        .head_ready_i(head_ready),
        .accept_i    (store_accept_i),
        .request_o   (drain_req),
        .pop_o       (pop)
    );

    always_comb begin
        store_req_o.valid   = drain_req;
        store_req_o.addr    = entry_addr[head_idx];
        store_req_o.data    = entry_data[head_idx];
        store_req_o.rob_idx = entry_rob[head_idx];
    end

endmodule

`default_nettype wire

//--- logic/load_queue.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsq_macros.svh"

module load_queue
    import lsq_pkg::*;
(
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                enq_i,
    input  rob_idx_t                            enq_rob_idx_i,
    input  exec_result_t                        exec_i,
    input  sq_ptr_t                             sq_tail_i,
    input  sq_ptr_t                             sq_head_i,
    input  logic [$clog2(`LSQ_SQ_DEPTH+1)-1:0] sq_count_i,
    output mem_req_t                            load_req_o,
    input  logic                                load_accept_i,
    input  mem_resp_t                           load_resp_i,
    output writeback_t                          writeback_o,
    output logic                                full_o
);

    localparam int DEPTH = `LSQ_LQ_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    // Entry payload
    rob_idx_t entry_rob [DEPTH];
    addr_t    entry_addr [DEPTH];
    data_t    entry_data [DEPTH];
    // Store queue tail seen at dispatch
    sq_ptr_t  entry_wait [DEPTH];

    // Entry status
    logic [DEPTH-1:0] entry_valid;
    logic [DEPTH-1:0] addr_known;
    logic [DEPTH-1:0] data_known;

    logic [DEPTH-1:0] exec_hit;
    logic [DEPTH-1:0] resp_hit;
    lq_ptr_t          head_ptr;
    lq_ptr_t          tail_ptr;
    lq_ptr_t          issue_q;
    logic [IDX_W-1:0] head_idx;
    logic [IDX_W-1:0] tail_idx;
    logic [IDX_W-1:0] issue_idx;
    sq_ptr_t          wait_dist;
    logic             older_drained;
    logic             issue_ready;
    logic             enq_ok;
    logic             pop;

    assign enq_ok    = enq_i && !full_o;
    assign head_idx  = head_ptr[IDX_W-1:0];
    assign tail_idx  = tail_ptr[IDX_W-1:0];
    assign issue_idx = issue_q[IDX_W-1:0];

    queue_pointers #(
        .DEPTH(DEPTH)
    ) i_pointers (
        .clock  (clock),
        .reset  (reset),
        .push_i (enq_ok),
        .pop_i  (pop),
        .head_o (head_ptr),
        .tail_o (tail_ptr),
        .count_o(),
        .full_o (full_o)
    );

    // ==============================
    // Address and response match
    // ==============================
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            exec_hit[i] = entry_valid[i] && exec_i.valid
                          && (entry_rob[i] == exec_i.rob_idx);
            resp_hit[i] = entry_valid[i] && !data_known[i] && load_resp_i.valid
                          && (entry_rob[i] == load_resp_i.rob_idx);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            addr_known  <= '0;
            data_known  <= '0;
        end else begin
            addr_known <= addr_known | exec_hit;
            data_known <= data_known | resp_hit;
            if (pop) begin
                entry_valid[head_idx] <= 1'b0;
            end
            if (enq_ok) begin
                entry_valid[tail_idx] <= 1'b1;
                addr_known[tail_idx]  <= 1'b0;
                data_known[tail_idx]  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq_ok) begin
            entry_rob[tail_idx]  <= enq_rob_idx_i;
            entry_wait[tail_idx] <= sq_tail_i;
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (exec_hit[i]) begin
                entry_addr[i] <= exec_i.addr;
            end
            if (resp_hit[i]) begin
                entry_data[i] <= load_resp_i.data;
            end
        end
    end

    // ==============================
    // In-order issue
    // ==============================
    // Older stores still queued sit between the SQ head and the wait tag
    assign wait_dist     = entry_wait[issue_idx] - sq_head_i;
    // Head already past the tag gives a wrapped distance
    assign older_drained = (wait_dist == '0) || (wait_dist > sq_count_i);
    // Issue pointer equal to tail means nothing left to issue
    assign issue_ready   = (issue_q != tail_ptr) && addr_known[issue_idx] && older_drained;

    always_ff @(posedge clock) begin
        if (reset) begin
            issue_q <= '0;
        end else if (issue_ready && load_accept_i) begin
            issue_q <= issue_q + lq_ptr_t'(1);
        end
    end

    always_comb begin
        load_req_o.valid   = issue_ready;
        load_req_o.addr    = entry_addr[issue_idx];
        load_req_o.data    = '0;
        load_req_o.rob_idx = entry_rob[issue_idx];
    end

    // In-order writeback, head leaves once its data is back
    assign pop = entry_valid[head_idx] && data_known[head_idx];

    always_comb begin
        writeback_o.valid   = pop;
        writeback_o.rob_idx = entry_rob[head_idx];
        writeback_o.data    = entry_data[head_idx];
    end

endmodule

`default_nettype wire

//--- logic/lsq_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsq_macros.svh"

module lsq_top
    import lsq_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  dispatch_t    dispatch_i,
    output logic         lsq_full_o,
    input  exec_result_t exec_i,
    input  logic         commit_valid_i,
    input  rob_idx_t     commit_rob_idx_i,
    output mem_req_t     load_req_o,
    input  logic         load_accept_i,
    input  mem_resp_t    load_resp_i,
    output mem_req_t     store_req_o,
    input  logic         store_accept_i,
    output writeback_t   writeback_o
);

    logic    sq_enq;
    logic    lq_enq;
    logic    sq_full;
    logic    lq_full;
    sq_ptr_t sq_head;
    sq_ptr_t sq_tail;
    logic [$clog2(`LSQ_SQ_DEPTH+1)-1:0] sq_count;

    // ==============================
    // Dispatch steering
    // ==============================
    assign sq_enq     = dispatch_i.valid && dispatch_i.is_store;
    assign lq_enq     = dispatch_i.valid && !dispatch_i.is_store;
    // Stall from the queue this op is headed for
    assign lsq_full_o = dispatch_i.is_store ? sq_full : lq_full;

    store_queue i_store_queue (
        .clock           (clock),
        .reset           (reset),
        .enq_i           (sq_enq),
        .enq_rob_idx_i   (dispatch_i.rob_idx),
        .exec_i          (exec_i),
        .commit_valid_i  (commit_valid_i),
        .commit_rob_idx_i(commit_rob_idx_i),
        .store_req_o     (store_req_o),
        .store_accept_i  (store_accept_i),
        .full_o          (sq_full),
        .head_o          (sq_head),
        .tail_o          (sq_tail),
        .count_o         (sq_count)
    );

    // Loads track store order through the SQ pointers
    load_queue i_load_queue (
        .clock        (clock),
        .reset        (reset),
        .enq_i        (lq_enq),
        .enq_rob_idx_i(dispatch_i.rob_idx),
        .exec_i       (exec_i),
        .sq_tail_i    (sq_tail),
        .sq_head_i    (sq_head),
        .sq_count_i   (sq_count),
        .load_req_o   (load_req_o),
        .load_accept_i(load_accept_i),
        .load_resp_i  (load_resp_i),
        .writeback_o  (writeback_o),
        .full_o       (lq_full)
    );

endmodule

`default_nettype wire

//--- dv/lsq_tb_program.svh
`ifndef LSQ_TB_PROGRAM_SVH
`define LSQ_TB_PROGRAM_SVH

// ==============================
// Random program
// ==============================
logic  op_store     [NUM_OPS];
addr_t op_addr      [NUM_OPS];
data_t op_data      [NUM_OPS];
// Expected load data, memory replayed in program order
data_t exp_data     [NUM_OPS];
int    loads_before [NUM_OPS];
logic  exec_sent    [NUM_OPS];
int    commit_cycle [NUM_OPS];
// Op indexes per queue, program order
int    store_order  [$];
int    load_order   [$];

// Cache model state
data_t    cache_mem [NUM_WORDS];
rob_idx_t resp_rob  [$];
data_t    resp_data [$];
int       resp_due  [$];

function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
endfunction

// Window of live ops never reaches the ROB size
function automatic rob_idx_t rob_of(input int k);
    return rob_idx_t'(k % ROB_SLOTS);
endfunction

// Initial contents, a function of the whole word address
function automatic data_t fill_word(input int w);
    return data_t'(32'h5a00_0000 ^ (w * 32'h0001_0203));
endfunction

task automatic build_program();
    data_t ref_mem [NUM_WORDS];
    int    n_loads;
    n_loads = 0;
    for (int w = 0; w < NUM_WORDS; w++) begin
        ref_mem[w]   = fill_word(w);
        cache_mem[w] = fill_word(w);
    end
    for (int k = 0; k < NUM_OPS; k++) begin
        op_store[k]     = (rand_below(2) == 1);
        op_addr[k]      = addr_t'(rand_below(NUM_WORDS));
        op_data[k]      = data_t'($random(seed));
        loads_before[k] = n_loads;
        exec_sent[k]    = 1'b0;
        commit_cycle[k] = -1;
        if (op_store[k]) begin
            ref_mem[op_addr[k][WORD_BITS-1:0]] = op_data[k];
            store_order.push_back(k);
        end else begin
            exp_data[k] = ref_mem[op_addr[k][WORD_BITS-1:0]];
            load_order.push_back(k);
            n_loads++;
        end
    end
endtask

// ==============================
// Drivers
// ==============================
// Same op stays on the bus until it gets in
task automatic drive_dispatch();
    if (n_disp < NUM_OPS && cycle > IDLE_CYCLES && rand_below(4) != 0) begin
        dispatch_i.valid    <= 1'b1;
        dispatch_i.is_store <= op_store[n_disp];
        dispatch_i.rob_idx  <= rob_of(n_disp);
    end else begin
        dispatch_i.valid <= 1'b0;
    end
endtask

// Random pick among dispatched ops still waiting for exec
task automatic drive_exec();
    int k;
    exec_i.valid <= 1'b0;
    if (exec_lo < n_disp && rand_below(2) == 1) begin
        k = exec_lo + rand_below(n_disp - exec_lo);
        if (!exec_sent[k]) begin
            exec_i.valid   <= 1'b1;
            exec_i.rob_idx <= rob_of(k);
            exec_i.addr    <= op_addr[k];
            exec_i.data    <= op_data[k];
            exec_sent[k] = 1'b1;
        end
    end
    while (exec_lo < n_disp && exec_sent[exec_lo]) begin
        exec_lo++;
    end
endtask

// Stores commit in order, after every older load wrote back
task automatic drive_commit();
    int k;
    commit_valid_i <= 1'b0;
    if (n_commit < store_order.size()) begin
        k = store_order[n_commit];
        if (k < n_disp && l_wb >= loads_before[k] && rand_below(2) == 1) begin
            commit_valid_i   <= 1'b1;
            commit_rob_idx_i <= rob_of(k);
            commit_cycle[k] = cycle;
            n_commit++;
        end
    end
endtask

// Random accepts, one due response per cycle
task automatic drive_cache();
    load_accept_i     <= (rand_below(3) != 0);
    store_accept_i    <= (rand_below(3) != 0);
    load_resp_i.valid <= 1'b0;
    for (int i = 0; i < resp_due.size(); i++) begin
        if (resp_due[i] <= cycle) begin
            load_resp_i.valid   <= 1'b1;
            load_resp_i.rob_idx <= resp_rob[i];
            load_resp_i.data    <= resp_data[i];
            resp_due.delete(i);
            resp_rob.delete(i);
            resp_data.delete(i);
            break;
        end
    end
endtask

`endif

//--- dv/lsq_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "lsq_macros.svh"

module lsq_tb
    import lsq_pkg::*;
();

    localparam int NUM_OPS        = 200;
    localparam int NUM_WORDS      = 16;
    localparam int WORD_BITS      = 4;
    localparam int SQ_DEPTH       = `LSQ_SQ_DEPTH;
    localparam int LQ_DEPTH       = `LSQ_LQ_DEPTH;
    localparam int ROB_SLOTS      = 1 << `LSQ_ROB_WIDTH;
    localparam int RESET_CYCLES   = 5;
    localparam int IDLE_CYCLES    = 3;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40;

    typedef logic [127:0] value_t;

    // DUT inputs start known
    logic         clock            = 1'b0;
    logic         reset            = 1'b1;
    dispatch_t    dispatch_i       = '0;
    exec_result_t exec_i           = '0;
    logic         commit_valid_i   = 1'b0;
    rob_idx_t     commit_rob_idx_i = '0;
    logic         load_accept_i    = 1'b0;
    mem_resp_t    load_resp_i      = '0;
    logic         store_accept_i   = 1'b0;

    logic         lsq_full_o;
    mem_req_t     load_req_o;
    mem_req_t     store_req_o;
    writeback_t   writeback_o;

    // Model counters
    int       seed        = 32'h1df;
    int       reset_count = 0;
    int       cycle       = 0;
    int       n_disp      = 0;
    int       n_disp_st   = 0;
    int       n_disp_ld   = 0;
    int       exec_lo     = 0;
    int       n_commit    = 0;
    int       l_issue     = 0;
    int       l_wb        = 0;
    int       s_drain     = 0;
    logic     done        = 1'b0;
    logic     load_hold   = 1'b0;
    logic     store_hold  = 1'b0;
    mem_req_t last_load_req;
    mem_req_t last_store_req;

    `include "lsq_tb_program.svh"

    lsq_top i_lsq_top (
        .clock           (clock),
        .reset           (reset),
        .dispatch_i      (dispatch_i),
        .lsq_full_o      (lsq_full_o),
        .exec_i          (exec_i),
        .commit_valid_i  (commit_valid_i),
        .commit_rob_idx_i(commit_rob_idx_i),
        .load_req_o      (load_req_o),
        .load_accept_i   (load_accept_i),
        .load_resp_i     (load_resp_i),
        .store_req_o     (store_req_o),
        .store_accept_i  (store_accept_i),
        .writeback_o     (writeback_o)
    );

    // 40 ns period
    initial begin
        forever #20 clock = ~clock;
    end

    initial build_program();

    // ==============================
    // Failure reporting
    // ==============================
    task automatic check_equal(input string name, input value_t actual, input value_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "%s", what);
    endtask

    // ==============================
    // Output checks
    // ==============================
    // Sampled at the edge with state from the cycle just ended
    task automatic check_outputs();
        logic full_exp;
        full_exp = dispatch_i.is_store ? (n_disp_st - s_drain == SQ_DEPTH)
                                       : (n_disp_ld - l_wb == LQ_DEPTH);
        check_equal("lsq_full_o", value_t'(lsq_full_o), value_t'(full_exp));
        // Nothing may move before the first dispatch
        if (n_disp == 0) begin
            check_equal("load_req_o.valid", value_t'(load_req_o.valid), '0);
            check_equal("store_req_o.valid", value_t'(store_req_o.valid), '0);
            check_equal("writeback_o.valid", value_t'(writeback_o.valid), '0);
        end
        // Request frozen until accepted
        if (load_hold) begin
            check_equal("load_req_o", value_t'(load_req_o), value_t'(last_load_req));
        end
        if (store_hold) begin
            check_equal("store_req_o", value_t'(store_req_o), value_t'(last_store_req));
        end
        load_hold      = load_req_o.valid && !load_accept_i;
        store_hold     = store_req_o.valid && !store_accept_i;
        last_load_req  = load_req_o;
        last_store_req = store_req_o;
    endtask

    task automatic observe_ports();
        int k;
        if (dispatch_i.valid && !lsq_full_o) begin
            if (dispatch_i.is_store) begin
                n_disp_st++;
            end else begin
                n_disp_ld++;
            end
            n_disp++;
        end
        // Load accept reads memory before a same-edge store writes it
        if (load_req_o.valid && load_accept_i) begin
            if (l_issue >= load_order.size()) begin
                abort_run("load request with no load left to issue");
            end else begin
                k = load_order[l_issue];
                check_equal("load_req_o.rob_idx", value_t'(load_req_o.rob_idx),
                            value_t'(rob_of(k)));
                check_equal("load_req_o.addr", value_t'(load_req_o.addr), value_t'(op_addr[k]));
                check_equal("load_req_o.data", value_t'(load_req_o.data), '0);
                check_equal("older stores drained", value_t'(s_drain >= k - loads_before[k]),
                            value_t'(1'b1));
                resp_rob.push_back(load_req_o.rob_idx);
                resp_data.push_back(cache_mem[load_req_o.addr[WORD_BITS-1:0]]);
                resp_due.push_back(cycle + 1 + rand_below(6));
                l_issue++;
            end
        end
        if (store_req_o.valid) begin
            if (s_drain >= store_order.size()) begin
                abort_run("store request with no store left to drain");
            end else begin
                k = store_order[s_drain];
                check_equal("store_req_o.rob_idx", value_t'(store_req_o.rob_idx),
                            value_t'(rob_of(k)));
                check_equal("store_req_o.addr", value_t'(store_req_o.addr),
                            value_t'(op_addr[k]));
                check_equal("store_req_o.data", value_t'(store_req_o.data),
                            value_t'(op_data[k]));
                // Commit reaches the DUT one cycle later and the request comes after that
                if (commit_cycle[k] < 0 || cycle <= commit_cycle[k] + 1) begin
                    abort_run($sformatf("store op %0d requested before its commit", k));
                end else if (store_accept_i) begin
                    cache_mem[store_req_o.addr[WORD_BITS-1:0]] = store_req_o.data;
                    s_drain++;
                end
            end
        end
        // In-order writeback against the reference memory
        if (writeback_o.valid) begin
            if (l_wb >= l_issue) begin
                abort_run("writeback for a load that was never issued");
            end else begin
                k = load_order[l_wb];
                check_equal("writeback_o.rob_idx", value_t'(writeback_o.rob_idx),
                            value_t'(rob_of(k)));
                check_equal("writeback_o.data", value_t'(writeback_o.data),
                            value_t'(exp_data[k]));
                l_wb++;
            end
        end
    endtask

    // ==============================
    // Cycle loop
    // ==============================
    always @(posedge clock) begin
        if (reset_count < RESET_CYCLES) begin
            reset_count = reset_count + 1;
            reset <= (reset_count < RESET_CYCLES);
        end else begin
            cycle = cycle + 1;
            check_outputs();
            observe_ports();
            drive_dispatch();
            drive_exec();
            drive_commit();
            drive_cache();
            done = (n_disp == NUM_OPS) && (l_wb == load_order.size())
                   && (s_drain == store_order.size());
        end
    end

    // Run ends when drained or out of time
    initial begin
        wait (done || cycle >= TIMEOUT_CYCLES);
        @(negedge clock);
        if (done) begin
            check_equal("load_req_o.valid", value_t'(load_req_o.valid), '0);
            check_equal("store_req_o.valid", value_t'(store_req_o.valid), '0);
            check_equal("writeback_o.valid", value_t'(writeback_o.valid), '0);
            check_equal("responses outstanding", value_t'(resp_due.size()), '0);
            $display("%0d loads and %0d stores retired in %0d cycles",
                     load_order.size(), store_order.size(), cycle);
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run($sformatf(
                "timeout after %0d cycles, %0d of %0d loads and %0d of %0d stores done",
                cycle, l_wb, load_order.size(), s_drain, store_order.size()));
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+logic
+incdir+dv
logic/lsq_pkg.sv
logic/queue_pointers.sv
logic/store_drain_fsm.sv
logic/store_queue.sv
logic/load_queue.sv
logic/lsq_top.sv
dv/lsq_tb.sv

//--- Makefile
# Verilator build and run for the load/store queue testbench

VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing
TOP             ?= lsq_tb
BUILD_DIR       ?= obj_dir
FILE_LIST       ?= verilog.f

SOURCES := $(wildcard logic/*.sv logic/*.svh dv/*.sv dv/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuild only when a source or the file list changes
$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Pass only when the pass message shows up in the output
run: $(BIN)
	@out="$$($(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(BUILD_DIR)
